//--- flist.f
+incdir+hdl
hdl/adpcm_pkg.sv
hdl/adpcm_regs.sv
hdl/adpcm_addr_ring.sv
hdl/adpcm_rom_arbiter.sv
hdl/adpcm_top.sv
tests/adpcm_rom_model.sv
tests/adpcm_tb.sv

//--- Bender.yml
package:
  name: adpcm_a_addr

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/adpcm_pkg.sv
      - hdl/adpcm_regs.sv
      - hdl/adpcm_addr_ring.sv
      - hdl/adpcm_rom_arbiter.sv
      - hdl/adpcm_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/adpcm_rom_model.sv
      - tests/adpcm_tb.sv

//--- tests/adpcm_tb.sv
// Testbench for the ADPCM-A address subsystem with APB tasks, a nibble monitor and a row table
`timescale 1ns/1ns
`include "adpcm_cfg.svh"

module adpcm_tb;
    import adpcm_pkg::*;

    localparam int         REV         = `ADPCM_STEP_DIV * `ADPCM_CHANNELS; // Step revolution
    localparam int         APB_LIMIT   = 64;              // Command writes need at most 12
    localparam int         WATCHDOG    = 400000;
    localparam logic [7:0] A_KEY_ON    = 8'h00;
    localparam logic [7:0] A_KEY_OFF   = 8'h04;
    localparam logic [7:0] A_START     = 8'h08;
    localparam logic [7:0] A_END       = 8'h0C;
    localparam logic [7:0] A_STATUS    = 8'h10;
    localparam logic [7:0] A_HOST_ADDR = 8'h14;
    localparam logic [7:0] A_HOST_DATA = 8'h18;

    // One playback row, count is (end - start) * 512
    typedef struct packed {
        logic [2:0]  chan;
        logic [11:0] start_pg;
        logic [11:0] end_pg;
        logic [15:0] count;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        rom_en;
    logic [19:0] rom_addr;
    logic [7:0]  rom_data;
    logic        nib_valid;
    nibble_t     nib;

    logic [31:0]                lfsr = 32'h97ce_5239;
    row_t                       rows [6];
    logic [20:0]                exp_naddr [`ADPCM_CHANNELS]; // Next nibble address per channel
    int                         nib_cnt [`ADPCM_CHANNELS];
    logic [`ADPCM_CHANNELS-1:0] armed;                        // Channels a test has started
    int                         nib_total;
    int                         rom_reads;                    // ROM enables seen on the port
    int                         host_reads;                   // Host reads the tests issued
    int                         cycle;
    int                         errors;
    int                         test_errors;                  // Error count when the test began
    int                         tests_run;
    int                         tests_failed;
    string                      cur_test;

    adpcm_top adpcm_top_i (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
        .rom_en, .rom_addr, .rom_data, .nib_valid, .nib
    );

    adpcm_rom_model adpcm_rom_model_i (.clk, .rst_n, .rom_en, .rom_addr, .rom_data);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                                 // 4 ns period
    end

    always @(posedge clk) cycle <= cycle + 1;

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG);
        $display("Simulation failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model of the ROM and random numbers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};                         // One LFSR step per bit taken
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [7:0] rom_byte_at(input logic [19:0] a);
        return a[7:0] ^ a[15:8] ^ {4'h0, a[19:16]};
    endfunction

    function automatic logic [3:0] nibble_at(input logic [20:0] naddr);
        logic [7:0] b;
        b = rom_byte_at(naddr[20:1]);
        return naddr[0] ? b[3:0] : b[7:4];                     // Even nibble is the high half
    endfunction

    function automatic row_t make_row(input logic [2:0] ch, input int span, input int count);
        row_t r;
        r.chan     = ch;
        r.start_pg = 12'(rand_bits(11));                       // Eleven bits keep end from wrapping
        r.end_pg   = r.start_pg + 12'(span);
        r.count    = 16'(count);
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reporting and APB access
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERROR %s %s: expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
        errors++;
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("PASS %s", cur_test);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", cur_test, errors - test_errors);
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        int n;
        @(posedge clk);
        psel    <= 1'b1;                                       // Setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready && n < APB_LIMIT) begin                 // Command writes stall here
            @(negedge clk);
            n++;
        end
        if (!pready) begin
            $display("Timeout in %s: APB access to 0x%02h never got pready", cur_test, addr);
            errors++;
        end
        rdata = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, wdata, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata);
        apb_xfer(1'b0, addr, 32'd0, rdata);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test steps
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic wait_status(input int idx, input logic level, input int limit);
        logic [31:0] rd;
        int          t0;
        t0 = cycle;
        apb_read(A_STATUS, rd);
        while (rd[idx] !== level && cycle - t0 < limit) begin
            apb_read(A_STATUS, rd);
        end
        if (rd[idx] !== level) begin
            $display("Timeout in %s: STATUS bit %0d never became %0b", cur_test, idx, level);
            errors++;
        end
    endtask

    task automatic host_read_check(input logic [19:0] a);
        logic [31:0] rd;
        int          t0;
        apb_write(A_HOST_ADDR, {12'd0, a});
        host_reads++;
        t0 = cycle;
        apb_read(A_HOST_DATA, rd);
        while (!rd[31] && cycle - t0 < 200) begin             // Poll the valid bit
            apb_read(A_HOST_DATA, rd);
        end
        if (!rd[31]) begin
            $display("Timeout in %s: host read of 0x%05h never returned", cur_test, a);
            errors++;
        end else if (rd[7:0] !== rom_byte_at(a)) begin
            report_mismatch("HOST_DATA", rom_byte_at(a), rd[7:0]);
        end
    endtask

    task automatic program_row(input row_t r);
        apb_write(A_KEY_OFF, 32'd1 << r.chan);                 // Park the channel first
        apb_write(A_START, {13'd0, r.chan, 4'd0, r.start_pg});
        apb_write(A_END, {13'd0, r.chan, 4'd0, r.end_pg});
        exp_naddr[r.chan] = {r.start_pg, 9'd0};
        nib_cnt[r.chan]   = 0;
        armed[r.chan]     = 1'b1;
    endtask

    task automatic check_row(input row_t r);
        logic [31:0] rd;
        wait_status(8 + r.chan, 1'b1, (r.count + 16) * REV);   // End flag
        if (nib_cnt[r.chan] != r.count) begin
            report_mismatch($sformatf("ch%0d nibble count", r.chan), r.count, nib_cnt[r.chan]);
        end
        apb_read(A_STATUS, rd);
        if (rd[r.chan] !== 1'b1) begin
            report_mismatch($sformatf("ch%0d playing flag", r.chan), 1, rd[r.chan]);
        end
    endtask

    task automatic key_off_check(input row_t r);
        int t0;
        int quiet_at;
        int seen;
        program_row(r);
        apb_write(A_KEY_ON, 32'd1 << r.chan);
        t0 = cycle;
        while (nib_cnt[r.chan] < 64 && cycle - t0 < 64 * REV + 500) begin
            @(posedge clk);
        end
        if (nib_cnt[r.chan] < 64) begin
            $display("Timeout in %s: channel %0d never started playing", cur_test, r.chan);
            errors++;
        end
        apb_write(A_KEY_OFF, 32'd1 << r.chan);
        wait_status(r.chan, 1'b0, 20 * REV);                   // Playing flag drops
        t0       = cycle;
        quiet_at = cycle;
        seen     = nib_cnt[r.chan];
        while (cycle - quiet_at < 4 * REV && cycle - t0 < 40 * REV) begin
            @(posedge clk);
            if (nib_cnt[r.chan] != seen) begin
                seen     = nib_cnt[r.chan];
                quiet_at = cycle;
            end
        end
        if (cycle - quiet_at < 4 * REV) begin
            $display("Timeout in %s: channel %0d kept playing after KEY_OFF", cur_test, r.chan);
            errors++;
        end
        if (nib_cnt[r.chan] >= r.count) begin
            $display("ERROR %s: nibble count expected below %0d actual %0d",
                     cur_test, r.count, nib_cnt[r.chan]);
            errors++;
        end
    endtask

    // Nibble monitor follows each channel's address and checks every nibble
    always @(negedge clk) begin
        if (rst_n && nib_valid) begin
            if (!armed[nib.chan]) begin
                $display("Nibble on channel %0d that no test started, during %s",
                         nib.chan, cur_test);
                errors++;
            end else if (nib.data !== nibble_at(exp_naddr[nib.chan])) begin
                report_mismatch($sformatf("ch%0d nibble %0d", nib.chan, nib_cnt[nib.chan]),
                                nibble_at(exp_naddr[nib.chan]), nib.data);
            end
            exp_naddr[nib.chan] = exp_naddr[nib.chan] + 21'd1;
            nib_cnt[nib.chan]++;
            nib_total++;
        end
    end

    // Every ROM read belongs to one fetch or one host read
    always @(negedge clk) begin
        if (rst_n && rom_en) begin
            rom_reads++;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0] rd;
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        armed      = '0;
        cycle      = 0;
        errors     = 0;
        rom_reads  = 0;
        host_reads = 0;
        for (int c = 0; c < `ADPCM_CHANNELS; c++) begin
            nib_cnt[c]   = 0;
            exp_naddr[c] = '0;
        end
        rows[0] = make_row(3'd0, 1, 512);                      // Playback rows
        rows[1] = make_row(3'd3, 2, 1024);
        rows[2] = make_row(3'd5, 0, 0);                        // End equals start
        rows[3] = make_row(3'd1, 1, 512);                      // Played as a pair
        rows[4] = make_row(3'd4, 1, 512);
        rows[5] = make_row(3'd2, 2, 1024);                     // Cut short by KEY_OFF
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        start_test("reset_state");
        apb_read(A_STATUS, rd);
        if (rd !== 32'd0) report_mismatch("STATUS", 32'd0, rd);
        apb_read(A_HOST_DATA, rd);
        if (rd[31] !== 1'b0) report_mismatch("HOST_DATA valid", 0, rd[31]);
        repeat (2 * REV) @(posedge clk);                        // Observation window
        if (nib_total != 0) report_mismatch("nibble count", 0, nib_total);
        finish_test();

        start_test("host_read");
        host_read_check(20'(rand_bits(20)));
        finish_test();

        for (int i = 0; i < 3; i++) begin
            start_test($sformatf("row%0d_ch%0d", i, rows[i].chan));
            program_row(rows[i]);
            apb_write(A_KEY_ON, 32'd1 << rows[i].chan);
            check_row(rows[i]);
            finish_test();
        end

        start_test("two_channels");
        program_row(rows[3]);
        program_row(rows[4]);
        apb_write(A_KEY_ON, (32'd1 << rows[3].chan) | (32'd1 << rows[4].chan));
        host_read_check(20'(rand_bits(20)));                    // Shares the ROM with playback
        check_row(rows[3]);
        check_row(rows[4]);
        finish_test();

        start_test("key_off");
        key_off_check(rows[5]);
        finish_test();

        // All streams are idle now, so each ROM read has produced its result
        start_test("rom_traffic");
        if (rom_reads != nib_total + host_reads) begin
            report_mismatch("ROM reads", nib_total + host_reads, rom_reads);
        end
        finish_test();

        $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tests/adpcm_rom_model.sv
// Behavioral sample ROM that returns an address-derived byte after a fixed read latency
`timescale 1ns/1ns
`include "adpcm_cfg.svh"

module adpcm_rom_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rom_en,
    input  logic [19:0] rom_addr,
    output logic [7:0]  rom_data
);
    localparam int LAT = `ADPCM_ROM_LAT;

    logic [19:0] addr_q [LAT];  // Read addresses in flight, oldest at LAT-1
    logic        vld_q  [LAT];

    // Contents fold every address bit into the byte
    function automatic logic [7:0] contents(input logic [19:0] a);
        logic [7:0] top;
        top = {4'h0, a[19:16]};                             // Upper four bits land in the low nibble
        return a[7:0] ^ a[15:8] ^ top;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LAT; i++) begin
                vld_q[i]  <= 1'b0;
                addr_q[i] <= '0;
            end
        end else begin
            vld_q[0]  <= rom_en;
            addr_q[0] <= rom_addr;
            for (int i = 1; i < LAT; i++) begin
                vld_q[i]  <= vld_q[i-1];                    // One read per cycle moves along
                addr_q[i] <= addr_q[i-1];
            end
        end
    end

    assign rom_data = vld_q[LAT-1] ? contents(addr_q[LAT-1]) : 8'h00;

endmodule

//--- hdl/adpcm_top.sv
// Top level of the ADPCM-A address subsystem joining registers, address ring and ROM arbiter
`timescale 1ns/1ns

module adpcm_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [7:0]         paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               rom_en,
    output logic [19:0]        rom_addr,
    input  logic [7:0]         rom_data,
    output logic               nib_valid,
    output adpcm_pkg::nibble_t nib
);
    import adpcm_pkg::*;

    logic         cmd_valid;
    logic         cmd_ready;
    ring_cmd_t    cmd;
    slot_status_t status;
    logic         fetch_valid;
    fetch_t       fetch;
    logic         host_valid;
    logic         host_ready;
    logic [19:0]  host_addr;
    logic         host_rdata_valid;
    logic [7:0]   host_rdata;

    adpcm_regs adpcm_regs_i (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
        .cmd_valid, .cmd, .cmd_ready, .status,
        .host_valid, .host_addr, .host_ready, .host_rdata_valid, .host_rdata
    );

    adpcm_addr_ring adpcm_addr_ring_i (
        .clk, .rst_n, .cmd_valid, .cmd, .cmd_ready, .status, .fetch_valid, .fetch
    );

    adpcm_rom_arbiter adpcm_rom_arbiter_i (
        .clk, .rst_n, .fetch_valid, .fetch, .host_valid, .host_addr, .host_ready,
        .rom_en, .rom_addr, .rom_data, .host_rdata_valid, .host_rdata, .nib_valid, .nib
    );

endmodule

//--- hdl/adpcm_rom_arbiter.sv
// ROM port arbiter that serves ring fetches first and routes returned bytes to nibbles or host
`timescale 1ns/1ns
`include "adpcm_cfg.svh"

module adpcm_rom_arbiter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fetch_valid,
    input  adpcm_pkg::fetch_t    fetch,
    input  logic                 host_valid,
    input  logic [19:0]          host_addr,
    output logic                 host_ready,
    output logic                 rom_en,
    output logic [19:0]          rom_addr,
    input  logic [7:0]           rom_data,
    output logic                 host_rdata_valid,
    output logic [7:0]           host_rdata,
    output logic                 nib_valid,
    output adpcm_pkg::nibble_t   nib
);
    import adpcm_pkg::*;

    localparam int LAT = `ADPCM_ROM_LAT;

    // Owner of one ROM read in flight
    typedef struct packed {
        logic       vld;
        logic       host;  // Byte goes back to the register block
        logic [2:0] chan;
        logic       sel;
    } tag_t;

    tag_t tag_q [LAT];     // tag_q[LAT-1] lines up with rom_data
    tag_t tag_new;
    tag_t tag_out;
    logic host_grant;

    // The ring cannot stall, so the host only gets idle cycles
    assign host_ready = ~fetch_valid;
    assign host_grant = host_valid & host_ready;

    assign rom_en   = fetch_valid | host_grant;
    assign rom_addr = fetch_valid ? fetch.byte_addr : host_addr;

    always_comb begin
        tag_new.vld  = rom_en;
        tag_new.host = ~fetch_valid;
        tag_new.chan = fetch.chan;
        tag_new.sel  = fetch.sel;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LAT; i++) begin
                tag_q[i] <= '0;
            end
        end else begin
            tag_q[0] <= tag_new;
            for (int i = 1; i < LAT; i++) begin
                tag_q[i] <= tag_q[i-1];                        // One read enters per cycle
            end
        end
    end

    assign tag_out = tag_q[LAT-1];

    // Split the returned byte by owner
    assign nib_valid        = tag_out.vld & ~tag_out.host;
    assign nib.chan         = tag_out.chan;
    assign nib.data         = tag_out.sel ? rom_data[3:0] : rom_data[7:4];
    assign host_rdata_valid = tag_out.vld & tag_out.host;
    assign host_rdata       = rom_data;

    // A host grant never shares a cycle with a fetch, and its byte returns to the host
    a_host_excl: assert property (@(posedge clk) disable iff (!rst_n)
        host_grant |-> !fetch_valid ##LAT (host_rdata_valid && !nib_valid));

    // Every fetch yields its nibble for the same channel exactly LAT cycles later
    a_fetch_return: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_valid |-> ##LAT (nib_valid && nib.chan == $past(fetch.chan, LAT)));

endmodule

//--- hdl/adpcm_addr_ring.sv
// Six-slot nibble address ring that applies commands, steps playing channels and issues fetches
`timescale 1ns/1ns
`include "adpcm_cfg.svh"

module adpcm_addr_ring (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cmd_valid,
    input  adpcm_pkg::ring_cmd_t    cmd,
    output logic                    cmd_ready,
    output adpcm_pkg::slot_status_t status,
    output logic                    fetch_valid,
    output adpcm_pkg::fetch_t       fetch
);
    import adpcm_pkg::*;

    localparam int NCH   = `ADPCM_CHANNELS;
    localparam int REV_W = (`ADPCM_STEP_DIV > 1) ? $clog2(`ADPCM_STEP_DIV) : 1;

    // Channel context carried around the ring
    typedef struct packed {
        logic [20:0] addr;     // Nibble address, page in bits 20:9
        logic [11:0] start_pg;
        logic [11:0] end_pg;
        logic        on;
    } ctx_t;

    ctx_t             ctx [1:6];  // Stage registers, ctx[1] is the slot counted by slot_cnt
    ctx_t             ctx2_nxt;
    logic             clr2_nxt;
    logic             clr2;       // Key-on seen at stage 2, reload address at stage 3
    logic             done5;      // Page equals end page, computed from stage 4
    logic             done6;
    logic             sumup5;     // Stage 5 slot steps this cycle
    logic [2:0]       slot_cnt;   // Channel in stage 1
    logic [2:0]       chan_s5;
    logic [2:0]       chan_s6;
    logic [REV_W-1:0] rev_cnt;
    logic             slot_wrap;  // Slot 0 enters stage 1 at the next edge
    logic             busy;       // A latched command is being applied
    ring_cmd_t        cmd_q;

    assign slot_wrap = (slot_cnt == 3'(NCH - 1));
    assign chan_s5   = 3'((slot_cnt + NCH - 4) % NCH);
    assign chan_s6   = 3'((slot_cnt + NCH - 5) % NCH);
    assign sumup5    = ctx[5].on & ~done5 & (rev_cnt == '0);   // Only in the step revolution

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command application, stage 1 to stage 2
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        ctx2_nxt = ctx[1];
        clr2_nxt = 1'b0;
        if (busy && cmd_q.chan_mask[slot_cnt]) begin
            case (cmd_q.op)
                CMD_KEY_ON: begin
                    ctx2_nxt.on = 1'b1;
                    clr2_nxt    = 1'b1;                        // Restart from the start page
                end
                CMD_KEY_OFF:   ctx2_nxt.on       = 1'b0;
                CMD_SET_START: ctx2_nxt.start_pg = cmd_q.value;
                default:       ctx2_nxt.end_pg   = cmd_q.value;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i <= 6; i++) begin
                ctx[i] <= '0;
            end
            clr2  <= 1'b0;
            done5 <= 1'b0;
            done6 <= 1'b0;
        end else begin
            ctx[2] <= ctx2_nxt;
            clr2   <= clr2_nxt;
            ctx[3] <= ctx[2];
            if (clr2) begin
                ctx[3].addr <= {ctx[2].start_pg, 9'd0};       // Page to nibble address
            end
            ctx[4] <= ctx[3];
            ctx[5] <= ctx[4];
            done5  <= (ctx[4].addr[20:9] == ctx[4].end_pg);
            ctx[6] <= ctx[5];
            if (sumup5) begin
                ctx[6].addr <= ctx[5].addr + 21'd1;
            end
            done6  <= done5;
            ctx[1] <= ctx[6];                                 // Close the ring
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Slot, revolution and command handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_cnt    <= '0;
            rev_cnt     <= '0;
            busy        <= 1'b0;
            cmd_ready   <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            slot_cnt    <= slot_wrap ? 3'd0 : slot_cnt + 3'd1;
            cmd_ready   <= slot_wrap & busy;                  // Whole revolution applied
            fetch_valid <= sumup5;
            if (slot_wrap) begin
                rev_cnt <= (rev_cnt == REV_W'(`ADPCM_STEP_DIV - 1)) ? '0 : rev_cnt + 1'b1;
                busy    <= ~busy & cmd_valid;                 // Latch as slot 0 enters stage 1
            end
        end
    end

    always_ff @(posedge clk) begin
        if (slot_wrap && !busy && cmd_valid) begin
            cmd_q <= cmd;
        end
        fetch.chan      <= chan_s5;
        fetch.byte_addr <= ctx[5].addr[20:1];                 // Address before the step
        fetch.sel       <= ctx[5].addr[0];
    end

    assign status.chan = chan_s6;
    assign status.on   = ctx[6].on;
    assign status.done = ctx[6].on & done6;                   // Idle channels report no end

    // A ready pulse closes a revolution that started with a latched command
    a_ready_after_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_ready |-> $past(busy, NCH) && $past(cmd_valid, NCH + 1) && !$past(cmd_ready));

    // A slot reported done on its last pass steps again only if a command reached it at stage 1
    a_done_no_step: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_valid |-> !$past(status.done, NCH)
                        || $past(busy && cmd_q.chan_mask[slot_cnt], 5));

endmodule

//--- hdl/adpcm_regs.sv
// APB register block that issues ring commands, collects slot flags and runs the host ROM window
`timescale 1ns/1ns
`include "adpcm_cfg.svh"

module adpcm_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [7:0]              paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    cmd_valid,
    output adpcm_pkg::ring_cmd_t    cmd,
    input  logic                    cmd_ready,
    input  adpcm_pkg::slot_status_t status,
    output logic                    host_valid,
    output logic [19:0]             host_addr,
    input  logic                    host_ready,
    input  logic                    host_rdata_valid,
    input  logic [7:0]              host_rdata
);
    import adpcm_pkg::*;

    localparam int         NCH         = `ADPCM_CHANNELS;
    localparam logic [7:0] A_STATUS    = 8'h10;
    localparam logic [7:0] A_HOST_ADDR = 8'h14;
    localparam logic [7:0] A_HOST_DATA = 8'h18;

    logic            access;    // APB access phase
    logic            wr_cmd;    // Write to one of the four command registers
    logic            wr_host;   // Write to HOST_ADDR
    logic            cmd_pend;  // Command handed to the ring, waiting for cmd_ready
    logic            host_pend; // Host read waiting for a ROM slot
    logic            host_dvld; // HOST_DATA holds the byte of the last HOST_ADDR
    logic [7:0]      host_dq;
    logic [NCH-1:0]  play_q;    // Playing flags per channel
    logic [NCH-1:0]  end_q;     // End flags per channel
    ring_cmd_t       cmd_nxt;
    ring_cmd_t       cmd_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign access  = psel & penable;
    assign wr_cmd  = access & pwrite & (paddr[7:4] == 4'h0);   // 0x00 to 0x0C
    assign wr_host = access & pwrite & (paddr == A_HOST_ADDR);

    // Command writes stall until the ring has finished a whole revolution
    assign pready = access & (~wr_cmd | (cmd_pend & cmd_ready));

    always_comb begin
        cmd_nxt.op        = cmd_op_e'(paddr[3:2]);              // Register order is enum order
        cmd_nxt.value     = pwdata[11:0];
        cmd_nxt.chan_mask = {{(NCH-1){1'b0}}, 1'b1} << pwdata[18:16]; // START and END one-hot
        if (paddr[3] == 1'b0) begin
            cmd_nxt.chan_mask = pwdata[NCH-1:0];                // KEY_ON and KEY_OFF carry a mask
        end
    end

    always_comb begin
        case (paddr)
            A_STATUS:    prdata = 32'(play_q) | (32'(end_q) << 8);
            A_HOST_DATA: prdata = {host_dvld, 23'd0, host_dq};
            default:     prdata = 32'd0;                        // Write-only and unmapped read zero
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command, host window and flag state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_pend  <= 1'b0;
            host_pend <= 1'b0;
            host_dvld <= 1'b0;
            play_q    <= '0;
            end_q     <= '0;
        end else begin
            if (wr_cmd && !cmd_pend) begin
                cmd_pend <= 1'b1;                               // First access cycle hands it over
            end else if (cmd_pend && cmd_ready) begin
                cmd_pend <= 1'b0;                               // Ring done, APB transfer ends
            end
            if (wr_host) begin
                host_pend <= 1'b1;
            end else if (host_ready) begin
                host_pend <= 1'b0;                              // Granted this cycle
            end
            if (wr_host) begin
                host_dvld <= 1'b0;                              // New address invalidates the data
            end else if (host_rdata_valid) begin
                host_dvld <= 1'b1;
            end
            play_q[status.chan] <= status.on;                   // One slot refreshed per cycle
            end_q[status.chan]  <= status.done;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_cmd && !cmd_pend) begin
            cmd_q <= cmd_nxt;
        end
        if (wr_host) begin
            host_addr <= pwdata[19:0];
        end
        if (host_rdata_valid) begin
            host_dq <= host_rdata;
        end
    end

    assign cmd_valid  = cmd_pend;
    assign cmd        = cmd_q;
    assign host_valid = host_pend;

endmodule

//--- hdl/adpcm_pkg.sv
// Shared opcode enum and packed structs passed between the ADPCM-A address blocks
`include "adpcm_cfg.svh"

package adpcm_pkg;

    // Command opcodes, ordered like the command registers in the APB map
    typedef enum logic [1:0] {
        CMD_KEY_ON    = 2'd0,
        CMD_KEY_OFF   = 2'd1,
        CMD_SET_START = 2'd2,
        CMD_SET_END   = 2'd3
    } cmd_op_e;

    // One command for the ring, applied to every slot in the mask
    typedef struct packed {
        cmd_op_e                    op;        // What to do
        logic [`ADPCM_CHANNELS-1:0] chan_mask; // One bit per channel
        logic [11:0]                value;     // Page for start and end commands
    } ring_cmd_t;

    // One playback fetch issued by a stepping slot
    typedef struct packed {
        logic [2:0]  chan;      // Channel that stepped
        logic [19:0] byte_addr; // ROM byte holding the nibble
        logic        sel;       // Nibble select, 0 is the high nibble
    } fetch_t;

    // Slot leaving the last ring stage
    typedef struct packed {
        logic [2:0] chan;
        logic       on;   // Channel is playing
        logic       done; // Channel reached its end page
    } slot_status_t;

    // One nibble on the playback stream
    typedef struct packed {
        logic [2:0] chan;
        logic [3:0] data;
    } nibble_t;

endpackage

//--- hdl/adpcm_cfg.svh
// Build-time parameters for the ADPCM-A address subsystem
`ifndef ADPCM_CFG_SVH
`define ADPCM_CFG_SVH

// Number of channel slots circulating through the address ring
`define ADPCM_CHANNELS 6

// Ring revolutions per step revolution, which sets the playback rate
`define ADPCM_STEP_DIV 3

// Cycles from a ROM enable to its data on rom_data
`define ADPCM_ROM_LAT  2

`endif
